/* source/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// register and data word
`define DATA_W 16
`define BYTE_W 8

// fetch word, opcode in the low byte
`define INST_W 24

// first fetch address after reset
`define RESET_VECTOR 16'h4000

// x, y and z
`define REG_COUNT 3

// bit positions in the flag byte, other bits read 0
`define FLAG_C 1
`define FLAG_N 2
`define FLAG_Z 3

`endif

/* source/cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

	// encodings are also listed in the trace file header
	typedef enum logic [`BYTE_W-1:0] {
		OPCODE_NOP         = 8'h00,
		OPCODE_TRAP        = 8'h01,
		OPCODE_LD_XL_IMMD  = 8'h10,
		OPCODE_ADD_XL_IMMD = 8'h11,
		OPCODE_SUB_XL_IMMD = 8'h12,
		OPCODE_AND_XL_IMMD = 8'h13,
		OPCODE_OR_XL_IMMD  = 8'h14,
		OPCODE_XOR_XL_IMMD = 8'h15,
		OPCODE_LDW_Y_IMMD  = 8'h20,
		OPCODE_LDW_Z_IMMD  = 8'h21,
		OPCODE_LD_XL_IY    = 8'h30,
		OPCODE_LD_IZ_XL    = 8'h31,
		OPCODE_LDW_IZ_Y    = 8'h32,
		OPCODE_JP_IMMD     = 8'h40,
		OPCODE_JR_D        = 8'h41,
		OPCODE_JRZ_D       = 8'h42,
		OPCODE_JRNZ_D      = 8'h43,
		OPCODE_JRC_D       = 8'h44,
		OPCODE_JRNC_D      = 8'h45
	} opcode_t;

	typedef enum logic [2:0] {
		ALUOP_PASS,
		ALUOP_PASSW,
		ALUOP_ADD,
		ALUOP_SUB,
		ALUOP_AND,
		ALUOP_OR,
		ALUOP_XOR
	} alu_op_t;

	// register file addresses
	typedef enum logic [1:0] {
		REG_X = 2'd0,
		REG_Y = 2'd1,
		REG_Z = 2'd2
	} reg_sel_t;

	// ldw and jp
	typedef struct packed {
		logic [`DATA_W-1:0] immd;
		opcode_t            opcode;
	} inst_wide_t;

	// byte alu ops, ld xl and jr
	typedef struct packed {
		logic [`BYTE_W-1:0] unused;
		logic [`BYTE_W-1:0] immd;
		opcode_t            opcode;
	} inst_narrow_t;

	typedef union packed {
		inst_wide_t   wide;
		inst_narrow_t narrow;
	} inst_t;

endpackage

/* source/alu.sv */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module alu
(
	input  cpu_pkg::alu_op_t   alu_op,
	input  logic [`DATA_W-1:0] operand_a,
	input  logic [`DATA_W-1:0] operand_b,
	input  logic [`BYTE_W-1:0] flags,
	input  logic               flag_update,
	output logic [`DATA_W-1:0] result,
	output logic [`BYTE_W-1:0] next_flags
);

	logic [`BYTE_W-1:0] a_lo;
	logic [`BYTE_W-1:0] b_lo;
	logic [`BYTE_W:0]   sum;
	logic [`BYTE_W-1:0] byte_res;
	logic               sets_c;

	assign a_lo = operand_a[`BYTE_W-1:0];
	assign b_lo = operand_b[`BYTE_W-1:0];

	always_comb
	begin
		// sub is a + ~b + 1, carry out means no borrow
		if (alu_op == cpu_pkg::ALUOP_SUB)
			sum = {1'b0, a_lo} + {1'b0, ~b_lo} + 1'b1;
		else
			sum = {1'b0, a_lo} + {1'b0, b_lo};
		sets_c = 1'b0;
		case (alu_op)
			cpu_pkg::ALUOP_ADD, cpu_pkg::ALUOP_SUB:
			begin
				byte_res = sum[`BYTE_W-1:0];
				sets_c = 1'b1;
			end
			cpu_pkg::ALUOP_AND:
				byte_res = a_lo & b_lo;
			cpu_pkg::ALUOP_OR:
				byte_res = a_lo | b_lo;
			cpu_pkg::ALUOP_XOR:
				byte_res = a_lo ^ b_lo;
			default:
				byte_res = b_lo;
		endcase
		result = (alu_op == cpu_pkg::ALUOP_PASSW) ? operand_b :
			{{(`DATA_W-`BYTE_W){1'b0}}, byte_res};

		next_flags = '0;
		next_flags[`FLAG_C] = flags[`FLAG_C];
		next_flags[`FLAG_N] = flags[`FLAG_N];
		next_flags[`FLAG_Z] = flags[`FLAG_Z];
		if (flag_update && alu_op != cpu_pkg::ALUOP_PASS && alu_op != cpu_pkg::ALUOP_PASSW)
		begin
			next_flags[`FLAG_Z] = (byte_res == '0);
			next_flags[`FLAG_N] = byte_res[`BYTE_W-1];
			if (sets_c)
				next_flags[`FLAG_C] = sum[`BYTE_W];
		end
	end

endmodule

/* source/register_file.sv */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module register_file
(
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::reg_sel_t  reg_addr,
	input  logic [1:0]         reg_write_en,
	input  logic [`DATA_W-1:0] reg_write_data,
	input  logic [`BYTE_W-1:0] next_flags,
	output logic [`DATA_W-1:0] x,
	output logic [`DATA_W-1:0] y,
	output logic [`DATA_W-1:0] z,
	output logic [`DATA_W-1:0] next_y,
	output logic [`BYTE_W-1:0] flags
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];
	logic               y_sel;

	assign x = regs[cpu_pkg::REG_X];
	assign y = regs[cpu_pkg::REG_Y];
	assign z = regs[cpu_pkg::REG_Z];

	// y after this cycle's write, for a load through y right after ldw y
	assign y_sel = (reg_addr == cpu_pkg::REG_Y);
	assign next_y = {
		(y_sel && reg_write_en[1]) ? reg_write_data[`DATA_W-1:`BYTE_W] : y[`DATA_W-1:`BYTE_W],
		(y_sel && reg_write_en[0]) ? reg_write_data[`BYTE_W-1:0] : y[`BYTE_W-1:0]
	};

	always_ff @(posedge clk)
	begin
		if (reg_write_en[0])
			regs[reg_addr][`BYTE_W-1:0] <= reg_write_data[`BYTE_W-1:0];
		if (reg_write_en[1])
			regs[reg_addr][`DATA_W-1:`BYTE_W] <= reg_write_data[`DATA_W-1:`BYTE_W];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	a_reg_addr_valid: assert property (@(posedge clk)
		reg_write_en != 2'b00 |-> reg_addr < `REG_COUNT);

endmodule

/* source/decode_unit.sv */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module decode_unit
(
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::inst_t     inst,
	input  logic [`DATA_W-1:0] x,
	input  logic [`DATA_W-1:0] y,
	input  logic [`DATA_W-1:0] z,
	input  logic [`DATA_W-1:0] alu_result,
	input  logic [`DATA_W-1:0] dread_data,
	output cpu_pkg::alu_op_t   alu_op,
	output logic [`DATA_W-1:0] operand_a,
	output logic [`DATA_W-1:0] operand_b,
	output logic               flag_update,
	output cpu_pkg::reg_sel_t  reg_addr,
	output logic [1:0]         reg_write_en,
	output logic [`DATA_W-1:0] reg_write_data,
	output logic [`DATA_W-1:0] dwrite_addr,
	output logic [`DATA_W-1:0] dwrite_data,
	output logic [1:0]         dwrite_en,
	output logic               trap
);

	logic [`DATA_W-1:0] immd8;

	assign immd8 = {{(`DATA_W-`BYTE_W){1'b0}}, inst.narrow.immd};

	// stores always go through z, data comes out of the alu pass path
	assign dwrite_addr = z;
	assign dwrite_data = alu_result;
	assign reg_write_data = alu_result;

	always_comb
	begin
		alu_op = cpu_pkg::ALUOP_PASS;
		operand_a = {{(`DATA_W-`BYTE_W){1'b0}}, x[`BYTE_W-1:0]};
		operand_b = '0;
		flag_update = 1'b0;
		reg_addr = cpu_pkg::REG_X;
		reg_write_en = 2'b00;
		dwrite_en = 2'b00;
		case (inst.narrow.opcode)
			cpu_pkg::OPCODE_LD_XL_IMMD:
			begin
				operand_b = immd8;
				reg_write_en = 2'b01;
			end
			cpu_pkg::OPCODE_ADD_XL_IMMD, cpu_pkg::OPCODE_SUB_XL_IMMD, cpu_pkg::OPCODE_AND_XL_IMMD,
			cpu_pkg::OPCODE_OR_XL_IMMD, cpu_pkg::OPCODE_XOR_XL_IMMD:
			begin
				operand_b = immd8;
				flag_update = 1'b1;
				reg_write_en = 2'b01;
				case (inst.narrow.opcode)
					cpu_pkg::OPCODE_ADD_XL_IMMD:
						alu_op = cpu_pkg::ALUOP_ADD;
					cpu_pkg::OPCODE_SUB_XL_IMMD:
						alu_op = cpu_pkg::ALUOP_SUB;
					cpu_pkg::OPCODE_AND_XL_IMMD:
						alu_op = cpu_pkg::ALUOP_AND;
					cpu_pkg::OPCODE_OR_XL_IMMD:
						alu_op = cpu_pkg::ALUOP_OR;
					default:
						alu_op = cpu_pkg::ALUOP_XOR;
				endcase
			end
			cpu_pkg::OPCODE_LDW_Y_IMMD, cpu_pkg::OPCODE_LDW_Z_IMMD:
			begin
				alu_op = cpu_pkg::ALUOP_PASSW;
				operand_b = inst.wide.immd;
				reg_addr = (inst.wide.opcode == cpu_pkg::OPCODE_LDW_Y_IMMD) ?
					cpu_pkg::REG_Y : cpu_pkg::REG_Z;
				reg_write_en = 2'b11;
			end
			cpu_pkg::OPCODE_LD_XL_IY:
			begin
				operand_b = {{(`DATA_W-`BYTE_W){1'b0}}, dread_data[`BYTE_W-1:0]};
				reg_write_en = 2'b01;
			end
			cpu_pkg::OPCODE_LD_IZ_XL:
			begin
				operand_b = operand_a;
				dwrite_en = 2'b01;
			end
			cpu_pkg::OPCODE_LDW_IZ_Y:
			begin
				alu_op = cpu_pkg::ALUOP_PASSW;
				operand_b = y;
				dwrite_en = 2'b11;
			end
			// jumps, nop and trap write nothing
			default:
				flag_update = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			trap <= 1'b0;
		else
			trap <= (inst.narrow.opcode == cpu_pkg::OPCODE_TRAP);
	end

	// fetch loads a nop into inst while reset is held
	a_quiet_in_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> dwrite_en == 2'b00 && reg_write_en == 2'b00);

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module fetch_unit
(
	input  logic               clk,
	input  logic               reset,
	input  logic [`INST_W-1:0] iread_data,
	input  logic [`BYTE_W-1:0] next_flags,
	input  logic [`DATA_W-1:0] next_y,
	output logic [`DATA_W-1:0] iread_addr,
	output logic [`DATA_W-1:0] dread_addr,
	output cpu_pkg::inst_t     inst
);

	cpu_pkg::inst_t     next_inst;
	cpu_pkg::opcode_t   next_op;
	logic [`DATA_W-1:0] pc;
	logic [`DATA_W-1:0] next_pc;
	logic [`DATA_W-1:0] disp;
	logic [1:0]         inst_len;
	logic               is_jp;
	logic               taken;
	logic               reads_iy;

	assign next_inst = iread_data;
	assign next_op = next_inst.narrow.opcode;
	assign disp = {{(`DATA_W-`BYTE_W){next_inst.narrow.immd[`BYTE_W-1]}}, next_inst.narrow.immd};

	// only length, branch kind and y-indirect use of the fetched word
	always_comb
	begin
		inst_len = 2'd1;
		is_jp = 1'b0;
		taken = 1'b0;
		reads_iy = 1'b0;
		case (next_op)
			cpu_pkg::OPCODE_LD_XL_IMMD, cpu_pkg::OPCODE_ADD_XL_IMMD, cpu_pkg::OPCODE_SUB_XL_IMMD,
			cpu_pkg::OPCODE_AND_XL_IMMD, cpu_pkg::OPCODE_OR_XL_IMMD,
			cpu_pkg::OPCODE_XOR_XL_IMMD:
				inst_len = 2'd2;
			cpu_pkg::OPCODE_LDW_Y_IMMD, cpu_pkg::OPCODE_LDW_Z_IMMD:
				inst_len = 2'd3;
			cpu_pkg::OPCODE_JP_IMMD:
				is_jp = 1'b1;
			cpu_pkg::OPCODE_LD_XL_IY:
				reads_iy = 1'b1;
			cpu_pkg::OPCODE_JR_D:
				taken = 1'b1;
			cpu_pkg::OPCODE_JRZ_D:
				taken = next_flags[`FLAG_Z];
			cpu_pkg::OPCODE_JRNZ_D:
				taken = !next_flags[`FLAG_Z];
			cpu_pkg::OPCODE_JRC_D:
				taken = next_flags[`FLAG_C];
			cpu_pkg::OPCODE_JRNC_D:
				taken = !next_flags[`FLAG_C];
			default:
				inst_len = 2'd1;
		endcase
		// untaken jr still skips its displacement
		if (next_op inside {cpu_pkg::OPCODE_JR_D, cpu_pkg::OPCODE_JRZ_D, cpu_pkg::OPCODE_JRNZ_D,
			cpu_pkg::OPCODE_JRC_D, cpu_pkg::OPCODE_JRNC_D})
			inst_len = 2'd2;
	end

	always_comb
	begin
		if (reset)
			next_pc = `RESET_VECTOR;
		else if (is_jp)
			next_pc = next_inst.wide.immd;
		else if (taken)
			next_pc = pc + disp;
		else
			next_pc = pc + `DATA_W'(inst_len);
	end

	assign iread_addr = next_pc;
	assign dread_addr = reads_iy ? next_y : 'x;

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
		if (reset)
		begin
			inst.wide.immd <= '0;
			inst.wide.opcode <= cpu_pkg::OPCODE_NOP;
		end
		else
			inst <= next_inst;
	end

	a_iread_known: assert property (@(posedge clk)
		!reset && $past(!reset) |-> !$isunknown(iread_addr));

endmodule

/* source/cpu_core.sv */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu_core
(
	input  logic               clk,
	input  logic               reset,
	output logic [`DATA_W-1:0] iread_addr,
	input  logic [`INST_W-1:0] iread_data,
	output logic [`DATA_W-1:0] dread_addr,
	input  logic [`DATA_W-1:0] dread_data,
	output logic [`DATA_W-1:0] dwrite_addr,
	output logic [`DATA_W-1:0] dwrite_data,
	output logic [1:0]         dwrite_en,
	output logic               trap
);

	cpu_pkg::inst_t     inst;
	cpu_pkg::alu_op_t   alu_op;
	cpu_pkg::reg_sel_t  reg_addr;
	logic [`DATA_W-1:0] x;
	logic [`DATA_W-1:0] y;
	logic [`DATA_W-1:0] z;
	logic [`DATA_W-1:0] next_y;
	logic [`DATA_W-1:0] operand_a;
	logic [`DATA_W-1:0] operand_b;
	logic [`DATA_W-1:0] alu_result;
	logic [`DATA_W-1:0] reg_write_data;
	logic [1:0]         reg_write_en;
	logic [`BYTE_W-1:0] flags;
	logic [`BYTE_W-1:0] next_flags;
	logic               flag_update;

	fetch_unit fetch_i (.clk, .reset, .iread_data, .next_flags, .next_y, .iread_addr,
		.dread_addr, .inst);

	decode_unit decode_i (.clk, .reset, .inst, .x, .y, .z, .alu_result, .dread_data,
		.alu_op, .operand_a, .operand_b, .flag_update, .reg_addr, .reg_write_en,
		.reg_write_data, .dwrite_addr, .dwrite_data, .dwrite_en, .trap);

	alu alu_i (
		.alu_op,
		.operand_a,
		.operand_b,
		.flags,
		.flag_update,
		.result(alu_result),
		.next_flags
	);

	register_file regs_i (.clk, .reset, .reg_addr, .reg_write_en, .reg_write_data,
		.next_flags, .x, .y, .z, .next_y, .flags);

endmodule

/* tests/tb_memory.sv */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module tb_memory
(
	input  logic               clk,
	input  logic [`DATA_W-1:0] iread_addr,
	output logic [`INST_W-1:0] iread_data,
	input  logic [`DATA_W-1:0] dread_addr,
	output logic [`DATA_W-1:0] dread_data,
	input  logic [`DATA_W-1:0] dwrite_addr,
	input  logic [`DATA_W-1:0] dwrite_data,
	input  logic [1:0]         dwrite_en
);

	logic [`BYTE_W-1:0] mem [2**`DATA_W];
	logic [`DATA_W-1:0] iaddr_q;
	logic [`DATA_W-1:0] daddr_q;

	function automatic logic [`BYTE_W-1:0] read_byte(input logic [`DATA_W-1:0] addr);
		return mem[addr];
	endfunction

	task automatic load_byte(input logic [`DATA_W-1:0] addr, input logic [`BYTE_W-1:0] value);
		mem[addr] = value;
	endtask

	// background from both address bytes
	task automatic fill_pattern();
		int a;

		for (a = 0; a < 2**`DATA_W; a++)
			mem[a] = a[15:8] ^ a[7:0] ^ 8'ha5;
	endtask

	initial
	begin
		iread_data = '0;
		dread_data = '0;
	end

	always @(posedge clk)
	begin
		if (dwrite_en[0])
			mem[dwrite_addr] = dwrite_data[`BYTE_W-1:0];
		if (dwrite_en[1])
			mem[dwrite_addr + 16'd1] = dwrite_data[`DATA_W-1:`BYTE_W];
		iaddr_q = iread_addr;
		daddr_q = dread_addr;
	end

	// little-endian words, valid from the falling edge
	always @(negedge clk)
	begin
		iread_data <= {read_byte(iaddr_q + 16'd2), read_byte(iaddr_q + 16'd1), read_byte(iaddr_q)};
		dread_data <= {read_byte(daddr_q + 16'd1), read_byte(daddr_q)};
	end

endmodule

/* tests/cpu_tb.sv */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu_tb;

	logic               clk;
	logic               reset;
	logic [`DATA_W-1:0] iread_addr;
	logic [`INST_W-1:0] iread_data;
	logic [`DATA_W-1:0] dread_addr;
	logic [`DATA_W-1:0] dread_data;
	logic [`DATA_W-1:0] dwrite_addr;
	logic [`DATA_W-1:0] dwrite_data;
	logic [1:0]         dwrite_en;
	logic               trap;

	// expected events from the trace
	logic [`DATA_W-1:0] exp_waddr [$];
	logic [1:0]         exp_wen [$];
	logic [`DATA_W-1:0] exp_wdata [$];
	logic [`DATA_W-1:0] exp_fetch [$];
	int                 exp_traps;

	int                 errors;
	int                 cycle;
	int                 limit;
	int                 prog_bytes;
	int                 reset_edges;
	int                 write_count;
	int                 fetch_count;
	int                 trap_count;
	logic               trap_last;
	logic               trace_ok;
	logic [`DATA_W-1:0] prev_iaddr;

	cpu_core dut_i (.clk, .reset, .iread_addr, .iread_data, .dread_addr, .dread_data,
		.dwrite_addr, .dwrite_data, .dwrite_en, .trap);

	tb_memory mem_i (.clk, .iread_addr, .iread_data, .dread_addr, .dread_data,
		.dwrite_addr, .dwrite_data, .dwrite_en);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	task automatic check_word(input string name, input logic [`DATA_W-1:0] expected,
		input logic [`DATA_W-1:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_en(input string name, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %0t %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %0t %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	function automatic logic [`DATA_W-1:0] lane_mask(input logic [1:0] en);
		return {{`BYTE_W{en[1]}}, {`BYTE_W{en[0]}}};
	endfunction

	task automatic read_trace(output logic ok);
		int                 fd;
		int                 n;
		int                 i;
		string              line;
		string              kind;
		logic [`DATA_W-1:0] addr;
		logic [`DATA_W-1:0] data;
		logic [1:0]         en;
		logic [7:0]         b [8];

		fd = $fopen("tests/cpu_trace.txt", "r");
		ok = (fd != 0);
		while (ok && !$feof(fd))
		begin
			line = "";
			kind = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%s", kind);
			if (kind == "p")
			begin
				n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", kind, addr,
					b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]);
				for (i = 0; i < 8; i++)
					mem_i.load_byte(addr + 16'(i), b[i]);
				prog_bytes += 8;
			end
			else if (kind == "d")
			begin
				n = $sscanf(line, "%s %h %h", kind, addr, b[0]);
				mem_i.load_byte(addr, b[0]);
			end
			else if (kind == "w")
			begin
				n = $sscanf(line, "%s %h %h %h", kind, addr, en, data);
				exp_waddr.push_back(addr);
				exp_wen.push_back(en);
				exp_wdata.push_back(data);
			end
			else if (kind == "f")
			begin
				n = $sscanf(line, "%s %h", kind, addr);
				exp_fetch.push_back(addr);
			end
			else if (kind == "t")
				exp_traps++;
		end
		if (ok)
			$fclose(fd);
	endtask

	// stores must match the trace one for one, in order
	task automatic check_write();
		logic [`DATA_W-1:0] mask;

		write_count++;
		if (exp_waddr.size() == 0)
		begin
			errors++;
			$display("unexpected store of %h to %h at %0t", dwrite_data, dwrite_addr, $time);
		end
		else
		begin
			mask = lane_mask(exp_wen[0]);
			check_word("dwrite_addr", exp_waddr.pop_front(), dwrite_addr);
			check_en("dwrite_en", exp_wen.pop_front(), dwrite_en);
			check_word("dwrite_data", exp_wdata.pop_front() & mask, dwrite_data & mask);
		end
	endtask

	always @(posedge clk)
	begin
		cycle++;
		if (reset)
		begin
			reset_edges++;
			check_word("iread_addr", `RESET_VECTOR, iread_addr);
			// inst and trap are still unknown at the first edge
			if (reset_edges > 1)
			begin
				check_en("dwrite_en", 2'b00, dwrite_en);
				check_flag("trap", 1'b0, trap);
			end
		end
		else
		begin
			// the word fetched one edge earlier starts executing now
			if (fetch_count == 0)
				check_word("first fetch", `RESET_VECTOR, prev_iaddr);
			fetch_count++;
			if (exp_fetch.size() > 0 && exp_fetch[0] == prev_iaddr)
				void'(exp_fetch.pop_front());
			if (dwrite_en != 2'b00)
				check_write();
			if (trap_last)
				check_flag("trap", 1'b0, trap);
			if (trap)
				trap_count++;
			trap_last = trap;
		end
		prev_iaddr = iread_addr;
	end

	task automatic final_checks();
		if (exp_waddr.size() != 0)
		begin
			errors++;
			$display("%0d expected stores never happened, first one to %h",
				exp_waddr.size(), exp_waddr[0]);
		end
		if (exp_fetch.size() != 0)
		begin
			errors++;
			$display("expected fetch at %h was never seen in order", exp_fetch[0]);
		end
		if (trap_count != exp_traps)
		begin
			errors++;
			$display("saw %0d trap pulses where %0d were expected", trap_count, exp_traps);
		end
	endtask

	task automatic report_and_finish();
		$display("errors: %0d  stores: %0d  fetches: %0d  traps: %0d",
			errors, write_count, fetch_count, trap_count);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	initial
	begin
		reset = 1'b1;
		errors = 0;
		cycle = 0;
		limit = 0;
		prog_bytes = 0;
		reset_edges = 0;
		write_count = 0;
		fetch_count = 0;
		trap_count = 0;
		exp_traps = 0;
		trap_last = 1'b0;
		mem_i.fill_pattern();
		read_trace(trace_ok);
		if (!trace_ok)
		begin
			errors++;
			$display("could not open tests/cpu_trace.txt");
		end
		else
		begin
			limit = 4 * prog_bytes + 50;
			repeat (5) @(posedge clk);
			@(negedge clk);
			reset = 1'b0;
			// the program ends on its trap
			while (trap_count < exp_traps)
				@(negedge clk);
			repeat (2) @(negedge clk);
			final_checks();
		end
		report_and_finish();
	end

	initial
	begin
		wait (limit > 0);
		wait (cycle >= limit);
		errors++;
		$display("timeout after %0d cycles, the program never reached its trap", cycle);
		report_and_finish();
	end

endmodule

/* tests/cpu_trace.txt */
# p addr b0..b7: program bytes | d addr byte: data | w addr en data: store | f addr: fetch | t: trap
# 00 nop, 01 trap, 10 ld xl,n, 11 add, 12 sub, 13 and, 14 or, 15 xor, 20 ldw y,nn, 21 ldw z,nn
# 30 ld xl,(y), 31 ld (z),xl, 32 ldw (z),y, 40 jp nn, 41 jr, 42 jrz, 43 jrnz, 44 jrc, 45 jrnc
p 4000 21 00 90 10 3c 11 d0 31
p 4008 12 20 31 13 7f 31 14 81
p 4010 31 15 ed 31 43 05 42 04
p 4018 31 31 44 04 45 04 31 31
p 4020 10 20 12 10 42 06 45 06
p 4028 44 04 31 31 43 04 31 31
p 4030 31 20 00 80 30 31 20 34
p 4038 12 32 40 48 40 31 31 31
p 4040 01 41 00 31 31 31 31 31
p 4048 41 f8 00 00 00 00 00 00
d 8000 5a
w 9000 1 000c
w 9000 1 00ec
w 9000 1 006c
w 9000 1 00ed
w 9000 1 0000
w 9000 1 0010
w 9000 1 005a
w 9000 3 1234
f 4000
f 4016
f 401a
f 401c
f 4020
f 4026
f 4028
f 402c
f 4048
f 4040
t

/* vlog.f */
+incdir+source
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/decode_unit.sv
source/fetch_unit.sv
source/cpu_core.sv
tests/tb_memory.sv
tests/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_pkg.sv
      - source/alu.sv
      - source/register_file.sv
      - source/decode_unit.sv
      - source/fetch_unit.sv
      - source/cpu_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_memory.sv
      - tests/cpu_tb.sv
